/* common/fetch_pkg.sv */
// --------------------
// Fetch stage package
// Widths, host address map and the structs passed between fetch blocks
// --------------------
`default_nettype none

package fetch_pkg;

  // Width of pc and of one instruction
  parameter int XLEN = 32;

  // Start register, everything below maps to instruction words
  parameter logic [XLEN-1:0] START_ADDR = 32'h0001_0000;

  // AXI response codes in use
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_t;

  // --------------------
  // Stage payloads
  // --------------------

  // Pair handed to decode, also the queue entry
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
  } f2d_t;

  // Fetch read request toward the memory
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic            epoch;
  } imem_rd_t;

  // Memory answer, one cycle after the request
  typedef struct packed {
    f2d_t f2d;
    logic epoch;
    logic hit;    // word was loaded and in range
  } imem_rsp_t;

  // Start command from the host side
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] target;
  } redirect_t;

endpackage

`default_nettype wire

/* rtl/fetch_axil_loader.sv */
// --------------------
// AXI4-Lite host loader
// Writes and reads instruction words, holds the start register and
// pulses a redirect toward the pc generator on a start write
// --------------------
`default_nettype none

module fetch_axil_loader #(
  parameter int  IMEM_DEPTH = 256,
  localparam int IDX_W      = $clog2(IMEM_DEPTH)
) (
  input  logic                           clk,
  input  logic                           rst,
  // AXI4-Lite write side
  input  logic [fetch_pkg::XLEN-1:0]     awaddr,
  input  logic                           awvalid,
  output logic                           awready,
  input  logic [fetch_pkg::XLEN-1:0]     wdata,
  input  logic [fetch_pkg::XLEN/8-1:0]   wstrb,
  input  logic                           wvalid,
  output logic                           wready,
  output fetch_pkg::axil_resp_t          bresp,
  output logic                           bvalid,
  input  logic                           bready,
  // AXI4-Lite read side
  input  logic [fetch_pkg::XLEN-1:0]     araddr,
  input  logic                           arvalid,
  output logic                           arready,
  output logic [fetch_pkg::XLEN-1:0]     rdata,
  output fetch_pkg::axil_resp_t          rresp,
  output logic                           rvalid,
  input  logic                           rready,
  // Memory host port
  output logic                           mem_we,
  output logic [IDX_W-1:0]               mem_widx,
  output logic [fetch_pkg::XLEN-1:0]     mem_wdata,
  output logic [IDX_W-1:0]               mem_ridx,
  input  logic [fetch_pkg::XLEN-1:0]     mem_rdata,
  // Start command
  output fetch_pkg::redirect_t           redirect
);

  import fetch_pkg::*;

  // Byte size of the instruction window
  localparam logic [XLEN-1:0] MEM_BYTES = XLEN'(IMEM_DEPTH * 4);

  logic            wr_rdy;
  logic            wr_hs;
  logic            wr_in_mem;
  logic            wr_start;
  logic            wr_full;
  logic            start_hs;
  logic [XLEN-1:0] start_q;
  logic [XLEN-1:0] start_merged;
  logic            ar_hs;
  logic            rd_pend;
  logic            rd_ok;

  // --------------------
  // Write channel
  // --------------------

  // AW and W accepted together
  assign awready = wr_rdy;
  assign wready  = wr_rdy;
  assign wr_hs   = awvalid & wr_rdy;

  // Address decode at the handshake
  assign wr_in_mem = awaddr < MEM_BYTES;
  assign wr_start  = awaddr == START_ADDR;
  assign wr_full   = &wstrb;
  assign start_hs  = wr_hs & wr_start;

  // Ready pulse, one write at a time
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_rdy <= 1'b0;
      bvalid <= 1'b0;
    end else begin
      wr_rdy <= awvalid & wvalid & ~wr_rdy & ~bvalid;
      if (wr_hs) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // Partial strobe only makes sense here
  always_ff @(posedge clk) begin
    if (wr_hs) begin
      bresp <= (wr_start | (wr_in_mem & wr_full)) ? OKAY : SLVERR;
    end
  end

  // Byte merge into the old start value
  always_comb begin
    start_merged = start_q;
    for (int i = 0; i < XLEN / 8; i++) begin
      if (wstrb[i]) begin
        start_merged[8*i +: 8] = wdata[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      start_q <= '0;
    end else if (start_hs) begin
      start_q <= start_merged;
    end
  end

  // Redirect fires in the handshake cycle
  assign redirect = '{valid: start_hs, target: start_merged};

  // Instruction word writes need a full strobe
  assign mem_we    = wr_hs & wr_in_mem & wr_full;
  assign mem_widx  = awaddr[IDX_W+1:2];
  assign mem_wdata = wdata;

  // --------------------
  // Read channel
  // --------------------

  assign ar_hs    = arvalid & arready;
  assign mem_ridx = araddr[IDX_W+1:2];

  // AR, then memory cycle, then R
  always_ff @(posedge clk) begin
    if (rst) begin
      arready <= 1'b0;
      rd_pend <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= arvalid & ~arready & ~rd_pend & ~rvalid;
      rd_pend <= ar_hs;
      if (rd_pend) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // Out-of-window reads give zero data
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rd_ok <= araddr < MEM_BYTES;
    end
    if (rd_pend) begin
      rdata <= rd_ok ? mem_rdata : '0;
      rresp <= rd_ok ? OKAY : SLVERR;
    end
  end

endmodule

`default_nettype wire

/* rtl/fetch_imem.sv */
// --------------------
// Instruction memory
// Word RAM with a loaded bit per word, host port and fetch read port
// --------------------
`default_nettype none

module fetch_imem #(
  parameter int  IMEM_DEPTH = 256,
  localparam int IDX_W      = $clog2(IMEM_DEPTH)
) (
  input  logic                       clk,
  input  logic                       rst,
  // Host port
  input  logic                       mem_we,
  input  logic [IDX_W-1:0]           mem_widx,
  input  logic [fetch_pkg::XLEN-1:0] mem_wdata,
  input  logic [IDX_W-1:0]           mem_ridx,
  output logic [fetch_pkg::XLEN-1:0] mem_rdata,
  // Fetch port
  input  logic                       rd_valid,
  input  fetch_pkg::imem_rd_t        rd,
  output logic                       rsp_valid,
  output fetch_pkg::imem_rsp_t       rsp
);

  import fetch_pkg::*;

  localparam logic [XLEN-1:0] MEM_BYTES = XLEN'(IMEM_DEPTH * 4);

  logic [XLEN-1:0]       words [IMEM_DEPTH];
  logic [IMEM_DEPTH-1:0] loaded;
  logic [IDX_W-1:0]      fidx;
  logic                  f_in_range;

  assign fidx       = rd.pc[IDX_W+1:2];
  assign f_in_range = rd.pc < MEM_BYTES;

  // Storage
  always_ff @(posedge clk) begin
    if (mem_we) begin
      words[mem_widx] <= mem_wdata;
    end
  end

  // Loaded bits, cleared on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      loaded <= '0;
    end else if (mem_we) begin
      loaded[mem_widx] <= 1'b1;
    end
  end

  // Host readback, zero when never loaded
  always_ff @(posedge clk) begin
    mem_rdata <= loaded[mem_ridx] ? words[mem_ridx] : '0;
  end

  // Fetch answer exactly one cycle later
  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= rd_valid;
    end
  end

  always_ff @(posedge clk) begin
    rsp.f2d.pc   <= rd.pc;
    rsp.f2d.inst <= words[fidx];
    rsp.epoch    <= rd.epoch;
    rsp.hit      <= f_in_range & loaded[fidx];
  end

endmodule

`default_nettype wire

/* fetch/fetch_pc_gen.sv */
// --------------------
// Fetch pc generator
// Walks the pc, handles redirects and squashes with an epoch bit,
// rewinds on a miss and issues only within queue credit
// --------------------
`default_nettype none

module fetch_pc_gen (
  input  logic                       clk,
  input  logic                       rst,
  input  fetch_pkg::redirect_t       redirect,
  input  logic                       squash,
  input  logic [fetch_pkg::XLEN-1:0] branch_target,
  input  logic                       rsp_valid,
  input  fetch_pkg::imem_rsp_t       rsp,
  input  logic [1:0]                 queue_count,
  output logic                       rd_valid,
  output fetch_pkg::imem_rd_t        rd,
  output logic                       epoch
);

  import fetch_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic            running;
  logic [1:0]      inflight;
  logic            miss;
  logic            credit;

  // --------------------
  // Issue control
  // --------------------

  // Miss of the current epoch only, stale ones are ignored
  assign miss = rsp_valid & ~rsp.hit & (rsp.epoch == epoch);

  // Queued plus outstanding must stay below two
  assign credit = (3'(queue_count) + 3'(inflight)) < 3'd2;

  // No issue while the pc is being replaced
  assign rd_valid = running & credit & ~redirect.valid & ~squash & ~miss;
  assign rd       = '{pc: pc_q, epoch: epoch};

  // --------------------
  // Pc and state
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q     <= '0;
      running  <= 1'b0;
      epoch    <= 1'b0;
      inflight <= '0;
    end else begin
      inflight <= inflight + 2'(rd_valid) - 2'(rsp_valid);
      // Start command, also the only way to begin
      if (redirect.valid) begin
        pc_q    <= redirect.target;
        epoch   <= ~epoch;
        running <= 1'b1;
      // Decode squash to a branch target
      end else if (squash) begin
        pc_q  <= branch_target;
        epoch <= ~epoch;
      // Retry the missed word next cycle
      end else if (miss) begin
        pc_q <= rsp.f2d.pc;
      end else if (rd_valid) begin
        pc_q <= pc_q + XLEN'(4);
      end
    end
  end

endmodule

`default_nettype wire

/* fetch/fetch_out_queue.sv */
// --------------------
// Decode-facing queue
// Two entries, head is the registered val/f2d output,
// drops stale or missed answers and flushes on squash
// --------------------
`default_nettype none

module fetch_out_queue (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 rsp_valid,
  input  fetch_pkg::imem_rsp_t rsp,
  input  logic                 epoch,
  output logic [1:0]           queue_count,
  output logic                 val,
  output fetch_pkg::f2d_t      f2d,
  input  logic                 rdy,
  input  logic                 squash
);

  import fetch_pkg::*;

  f2d_t skid;
  logic skid_v;
  logic push;
  logic pop;
  logic head_free;
  logic head_from_skid;
  logic head_from_rsp;
  logic skid_load;

  // Only loaded words of the live epoch
  assign push = rsp_valid & rsp.hit & (rsp.epoch == epoch);

  // Transfer toward decode
  assign pop = val & rdy & ~squash;

  // --------------------
  // Entry steering
  // --------------------

  // Head refills from skid first, keeps order
  assign head_free      = ~val | pop;
  assign head_from_skid = head_free & skid_v;
  assign head_from_rsp  = head_free & ~skid_v & push;

  // Skid is empty here whenever credit was honored
  assign skid_load = push & ~head_from_rsp;

  assign queue_count = 2'(val) + 2'(skid_v);

  always_ff @(posedge clk) begin
    if (rst) begin
      val    <= 1'b0;
      skid_v <= 1'b0;
    end else if (squash) begin
      // Flush both entries
      val    <= 1'b0;
      skid_v <= 1'b0;
    end else begin
      val    <= head_from_skid | head_from_rsp | (val & ~pop);
      skid_v <= skid_load | (skid_v & ~head_from_skid);
    end
  end

  // Payload, holds while val and not rdy
  always_ff @(posedge clk) begin
    if (head_from_skid) begin
      f2d <= skid;
    end else if (head_from_rsp) begin
      f2d <= rsp.f2d;
    end
    if (skid_load) begin
      skid <= rsp.f2d;
    end
  end

endmodule

`default_nettype wire

/* rtl/fetch_top.sv */
// --------------------
// Fetch stage top
// Host loader, instruction memory, pc generator and decode queue
// --------------------
`default_nettype none

module fetch_top #(
  parameter int IMEM_DEPTH = 256
) (
  input  logic                         clk,
  input  logic                         rst,
  // AXI4-Lite host port
  input  logic [fetch_pkg::XLEN-1:0]   awaddr,
  input  logic                         awvalid,
  output logic                         awready,
  input  logic [fetch_pkg::XLEN-1:0]   wdata,
  input  logic [fetch_pkg::XLEN/8-1:0] wstrb,
  input  logic                         wvalid,
  output logic                         wready,
  output fetch_pkg::axil_resp_t        bresp,
  output logic                         bvalid,
  input  logic                         bready,
  input  logic [fetch_pkg::XLEN-1:0]   araddr,
  input  logic                         arvalid,
  output logic                         arready,
  output logic [fetch_pkg::XLEN-1:0]   rdata,
  output fetch_pkg::axil_resp_t        rresp,
  output logic                         rvalid,
  input  logic                         rready,
  // Decode side
  output logic                         val,
  output fetch_pkg::f2d_t              f2d,
  input  logic                         rdy,
  input  logic                         squash,
  input  logic [fetch_pkg::XLEN-1:0]   branch_target
);

  import fetch_pkg::*;

  localparam int IDX_W = $clog2(IMEM_DEPTH);

  logic             mem_we;
  logic [IDX_W-1:0] mem_widx;
  logic [XLEN-1:0]  mem_wdata;
  logic [IDX_W-1:0] mem_ridx;
  logic [XLEN-1:0]  mem_rdata;
  redirect_t        redirect;
  logic             rd_valid;
  imem_rd_t         rd;
  logic             rsp_valid;
  imem_rsp_t        rsp;
  logic             epoch;
  logic [1:0]       queue_count;
  logic             flush;

  // Start write empties the queue like a squash
  assign flush = squash | redirect.valid;

  fetch_axil_loader #(.IMEM_DEPTH(IMEM_DEPTH)) u_loader (
    .clk, .rst,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .mem_we, .mem_widx, .mem_wdata, .mem_ridx, .mem_rdata,
    .redirect
  );

  fetch_imem #(.IMEM_DEPTH(IMEM_DEPTH)) u_imem (
    .clk, .rst,
    .mem_we, .mem_widx, .mem_wdata, .mem_ridx, .mem_rdata,
    .rd_valid, .rd, .rsp_valid, .rsp
  );

  fetch_pc_gen u_pc_gen (
    .clk, .rst,
    .redirect, .squash, .branch_target,
    .rsp_valid, .rsp, .queue_count,
    .rd_valid, .rd, .epoch
  );

  fetch_out_queue u_queue (
    .clk, .rst,
    .rsp_valid, .rsp, .epoch, .queue_count,
    .val, .f2d, .rdy,
    .squash(flush)
  );

endmodule

`default_nettype wire

/* bench/fetch_checker.sv */
// --------------------
// Fetch stage protocol checker
// Decode handshake and AXI4-Lite valid/ready rules, bound into the top
// --------------------
`default_nettype none

module fetch_checker (
  input logic            clk,
  input logic            rst,
  // Decode side
  input logic            val,
  input logic            rdy,
  input logic            squash,
  input logic            flush,
  input fetch_pkg::f2d_t f2d,
  // AXI4-Lite valid/ready pairs
  input logic            awvalid,
  input logic            awready,
  input logic            wvalid,
  input logic            wready,
  input logic            bvalid,
  input logic            bready,
  input logic            arvalid,
  input logic            arready,
  input logic            rvalid,
  input logic            rready
);

  timeunit 1ns;
  timeprecision 1ps;

  // Failed assertions, read by the testbench summary
  int errors = 0;

  // --------------------
  // Decode handshake
  // --------------------

  // Held pair stays put until taken
  a_payload_hold: assert property (@(posedge clk) disable iff (rst)
    val && !rdy && !flush |=> val && $stable(f2d))
    else begin
      $error("payload changed while val high and rdy low");
      errors++;
    end

  // Squash empties the output
  a_squash_clears: assert property (@(posedge clk) disable iff (rst)
    squash |=> !val)
    else begin
      $error("val still high after squash");
      errors++;
    end

  // --------------------
  // AXI4-Lite
  // --------------------

  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
    awvalid && !awready |=> awvalid)
    else begin
      $error("awvalid dropped before awready");
      errors++;
    end

  a_w_hold: assert property (@(posedge clk) disable iff (rst)
    wvalid && !wready |=> wvalid)
    else begin
      $error("wvalid dropped before wready");
      errors++;
    end

  a_b_hold: assert property (@(posedge clk) disable iff (rst)
    bvalid && !bready |=> bvalid)
    else begin
      $error("bvalid dropped before bready");
      errors++;
    end

  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    arvalid && !arready |=> arvalid)
    else begin
      $error("arvalid dropped before arready");
      errors++;
    end

  a_r_hold: assert property (@(posedge clk) disable iff (rst)
    rvalid && !rready |=> rvalid)
    else begin
      $error("rvalid dropped before rready");
      errors++;
    end

endmodule

`default_nettype wire

/* bench/tb_fetch.sv */
// --------------------
// Fetch stage testbench
// AXI4-Lite host, decode model with random rdy, stream checks
// --------------------
`default_nettype none

module tb_fetch;

  timeunit 1ns;
  timeprecision 1ps;

  import fetch_pkg::*;

  localparam int IMEM_DEPTH = 256;
  localparam int TIMEOUT    = 1000;

  logic            clk;
  logic            rst;
  logic [31:0]     awaddr;
  logic            awvalid;
  logic            awready;
  logic [31:0]     wdata;
  logic [3:0]      wstrb;
  logic            wvalid;
  logic            wready;
  axil_resp_t      bresp;
  logic            bvalid;
  logic            bready;
  logic [31:0]     araddr;
  logic            arvalid;
  logic            arready;
  logic [31:0]     rdata;
  axil_resp_t      rresp;
  logic            rvalid;
  logic            rready;
  logic            val;
  f2d_t            f2d;
  logic            rdy;
  logic            squash;
  logic [31:0]     branch_target;

  // Reference words by byte address, accepted pairs in order
  logic [31:0]     ref_mem [logic [31:0]];
  f2d_t            got [$];
  logic [31:0]     rb_addr [5] = '{32'h000, 32'h01c, 32'h03c, 32'h100, 32'h13c};
  int              errors = 0;
  int              mark;
  int              tests_run = 0;
  int              tests_bad = 0;
  int              seed = 32'h96b0_f506;
  int              rnd;
  logic            rdy_random = 1'b0;
  logic [31:0]     data;
  axil_resp_t      resp;
  int              n;

  fetch_top #(.IMEM_DEPTH(IMEM_DEPTH)) i_dut (
    .clk, .rst,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .val, .f2d, .rdy, .squash, .branch_target
  );

  bind fetch_top fetch_checker u_checker (
    .clk, .rst, .val, .rdy, .squash, .flush, .f2d,
    .awvalid, .awready, .wvalid, .wready, .bvalid, .bready,
    .arvalid, .arready, .rvalid, .rready
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Decode model, rdy changes 1 ns after the edge
  always @(posedge clk) begin
    #1;
    rnd = $random(seed);
    rdy <= rdy_random ? rnd[0] : 1'b1;
  end

  // Transfers sampled mid-cycle, inputs and val are stable there
  always @(negedge clk) begin
    if (!rst && val && rdy && !squash) begin
      got.push_back(f2d);
    end
  end

  // Fill pattern over the whole address
  function automatic logic [31:0] inst_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b9) ^ 32'h5a0f_c3e1;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act == exp)
    else begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  // --------------------
  // AXI4-Lite host
  // --------------------

  task automatic axi_write(input logic [31:0] addr, input logic [31:0] dat,
                           input logic [3:0] strb, output axil_resp_t res);
    int k;
    @(posedge clk);
    #1;
    awaddr  = addr;
    wdata   = dat;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    k = 0;
    do begin
      @(negedge clk);
      k++;
    end while (!(awready && wready) && k < TIMEOUT);
    if (!(awready && wready)) begin
      $display("write to %h got no awready and wready before the timeout", addr);
      errors++;
    end
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    k = 0;
    while (!bvalid && k < TIMEOUT) begin
      @(negedge clk);
      k++;
    end
    if (!bvalid) begin
      $display("write to %h got no write response before the timeout", addr);
      errors++;
    end
    res = bresp;
    // Response taken one cycle late so bvalid must hold
    @(posedge clk);
    #1;
    bready = 1'b1;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [31:0] addr, output logic [31:0] dat,
                          output axil_resp_t res);
    int k;
    @(posedge clk);
    #1;
    araddr  = addr;
    arvalid = 1'b1;
    k = 0;
    do begin
      @(negedge clk);
      k++;
    end while (!arready && k < TIMEOUT);
    if (!arready) begin
      $display("read of %h got no arready before the timeout", addr);
      errors++;
    end
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    k = 0;
    while (!rvalid && k < TIMEOUT) begin
      @(negedge clk);
      k++;
    end
    if (!rvalid) begin
      $display("read of %h got no read data before the timeout", addr);
      errors++;
    end
    dat = rdata;
    res = rresp;
    // Data taken one cycle late so rvalid must hold
    @(posedge clk);
    #1;
    rready = 1'b1;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  task automatic load_word(input logic [31:0] addr);
    axil_resp_t res;
    axi_write(addr, inst_word(addr), 4'hf, res);
    check_eq($sformatf("load %h resp", addr), 32'(OKAY), 32'(res));
    ref_mem[addr] = inst_word(addr);
  endtask

  task automatic start_at(input string name, input logic [31:0] addr);
    axil_resp_t res;
    axi_write(START_ADDR, addr, 4'hf, res);
    check_eq({name, " start resp"}, 32'(OKAY), 32'(res));
  endtask

  // --------------------
  // Stream checks
  // --------------------

  // Whole accepted stream must be base, base+4, ... with reference words
  task automatic check_stream(input string name, input logic [31:0] base, input int count);
    int k;
    logic [31:0] pc;
    k = 0;
    while (got.size() < count && k < TIMEOUT) begin
      @(posedge clk);
      k++;
    end
    if (got.size() < count) begin
      $display("%s: only %0d of %0d pairs accepted before the timeout",
               name, got.size(), count);
      errors++;
    end
    for (int i = 0; i < got.size() && i < count; i++) begin
      pc = base + 32'(4 * i);
      check_eq($sformatf("%s pc[%0d]", name, i), pc, got[i].pc);
      check_eq($sformatf("%s inst[%0d]", name, i), ref_mem[pc], got[i].inst);
    end
  endtask

  // Nothing further may arrive within the window
  task automatic quiet_window(input string name, input int cycles, input int count);
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
    end
    check_eq({name, " pair count"}, 32'(count), 32'(got.size()));
  endtask

  task automatic test_begin();
    mark = errors + i_dut.u_checker.errors;
  endtask

  task automatic test_end(input string name);
    int diff;
    diff = errors + i_dut.u_checker.errors - mark;
    tests_run++;
    if (diff == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, diff);
      tests_bad++;
    end
  endtask

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    rst = 1'b1;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    rdy = 1'b0;
    squash = 1'b0;
    branch_target = '0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    // Two programs, 0x000..0x03c and 0x100..0x13c
    test_begin();
    for (int a = 'h000; a < 'h040; a += 4) load_word(32'(a));
    for (int a = 'h100; a < 'h140; a += 4) load_word(32'(a));
    foreach (rb_addr[i]) begin
      axi_read(rb_addr[i], data, resp);
      check_eq($sformatf("readback %h data", rb_addr[i]), ref_mem[rb_addr[i]], data);
      check_eq($sformatf("readback %h resp", rb_addr[i]), 32'(OKAY), 32'(resp));
    end
    axi_read(32'h200, data, resp);
    check_eq("unloaded read data", 32'h0, data);
    check_eq("unloaded read resp", 32'(OKAY), 32'(resp));
    // Partial strobe on an instruction word is refused
    axi_write(32'h080, 32'h1234_5678, 4'h3, resp);
    check_eq("partial strobe resp", 32'(SLVERR), 32'(resp));
    axi_write(32'(IMEM_DEPTH * 4), 32'hdead_beef, 4'hf, resp);
    check_eq("write beyond depth resp", 32'(SLVERR), 32'(resp));
    axi_read(32'(IMEM_DEPTH * 4), data, resp);
    check_eq("read beyond depth resp", 32'(SLVERR), 32'(resp));
    check_eq("read beyond depth data", 32'h0, data);
    axi_read(32'h0002_0000, data, resp);
    check_eq("read far address resp", 32'(SLVERR), 32'(resp));
    test_end("load_readback");

    test_begin();
    got.delete();
    start_at("seq_fetch", 32'h000);
    check_stream("seq_fetch", 32'h000, 16);
    test_end("seq_fetch");

    // Stalled at 0x040 until that word is loaded
    test_begin();
    quiet_window("stall", 60, 16);
    load_word(32'h040);
    check_stream("stall resume", 32'h000, 17);
    quiet_window("stall resume", 30, 17);
    test_end("stall_unloaded");

    test_begin();
    rdy_random = 1'b1;
    got.delete();
    start_at("backpressure", 32'h100);
    check_stream("backpressure", 32'h100, 16);
    quiet_window("backpressure", 40, 16);
    test_end("backpressure");

    // Squash in the middle of a running stream, then a new start
    test_begin();
    got.delete();
    start_at("squash", 32'h100);
    n = 0;
    while (got.size() < 3 && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (got.size() < 3) begin
      $display("squash: stream from 0x100 did not start before the timeout");
      errors++;
    end
    #1;
    squash = 1'b1;
    branch_target = 32'h020;
    got.delete();
    @(posedge clk);
    #1;
    squash = 1'b0;
    check_stream("squash", 32'h020, 9);
    quiet_window("squash", 30, 9);
    got.delete();
    start_at("restart", 32'h108);
    check_stream("restart", 32'h108, 14);
    quiet_window("restart", 30, 14);
    rdy_random = 1'b0;
    test_end("squash_redirect");

    $display("%0d tests run, %0d with errors, %0d check errors, %0d assertion errors",
             tests_run, tests_bad, errors, i_dut.u_checker.errors);
    if (errors == 0 && i_dut.u_checker.errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
common/fetch_pkg.sv
rtl/fetch_axil_loader.sv
rtl/fetch_imem.sv
fetch/fetch_pc_gen.sv
fetch/fetch_out_queue.sv
rtl/fetch_top.sv
bench/fetch_checker.sv
bench/tb_fetch.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the fetch stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f flist.f \
  --top-module tb_fetch \
  -Mdir obj_dir \
  -o sim_fetch

./obj_dir/sim_fetch +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "tests failed" sim.log; then
  echo "simulation reported failures, see sim.log"
  exit 1
fi

grep -q "all tests passed" sim.log
echo "simulation finished cleanly"
